/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= core_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/core_pkg.sv */
// shared widths, encodings and stage structs; imported by every core module
package core_pkg;

  localparam int xlen = 64;

  typedef logic [4:0] reg_addr_t;

  typedef enum logic [6:0] {
    op_lui    = 7'h37,
    op_auipc  = 7'h17,
    op_jal    = 7'h6f,
    op_jalr   = 7'h67,
    op_branch = 7'h63,
    op_load   = 7'h03,
    op_store  = 7'h23,
    op_imm    = 7'h13,
    op_reg    = 7'h33,
    op_trap   = 7'h6b
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // br_cond takes its compare from funct3
  typedef enum logic [2:0] {br_none, br_jal, br_jalr, br_cond} br_kind_e;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t rs2;
      reg_addr_t rs1;
      logic [2:0] funct3;
      reg_addr_t rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      reg_addr_t rs1;
      logic [2:0] funct3;
      reg_addr_t rd;
      logic [6:0] opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      reg_addr_t rs2;
      reg_addr_t rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic imm_12;
      logic [5:0] imm_10_5;
      reg_addr_t rs2;
      reg_addr_t rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic imm_11;
      logic [6:0] opcode;
    } b_fmt;
    // also read as the j format
    struct packed {
      logic [19:0] imm_31_12;
      reg_addr_t rd;
      logic [6:0] opcode;
    } u_fmt;
  } inst_u;

  typedef struct packed {
    alu_op_e alu_op;
    br_kind_e br_kind;
    logic [2:0] funct3;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
    logic is_load;
  } exe_req_t;

  typedef struct packed {
    logic ren;
    logic wen;
    logic size_d;
    logic [xlen-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic wen;
    reg_addr_t rd;
    logic [xlen-1:0] data;
  } wb_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    logic [31:0] inst;
    logic wen;
    reg_addr_t wdest;
    logic [xlen-1:0] wdata;
  } commit_t;

endpackage

/* logic/commit_tracker.sv */
// records each retired instruction and the trap event for the testbench
`timescale 1ns/100ps

module commit_tracker import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic [xlen-1:0] pc_i,
  input  inst_u           inst_i,
  input  wb_t             wb_i,
  input  logic            is_trap_i,
  input  logic [xlen-1:0] x10_i,
  output commit_t         commit_o,
  output logic            trap_o,
  output logic [7:0]      trap_code_o,
  output logic [xlen-1:0] instr_cnt_o,
  output logic [xlen-1:0] cycle_cnt_o
);

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_o    <= '0;
      trap_o      <= 1'b0;
      trap_code_o <= '0;
      instr_cnt_o <= '0;
      cycle_cnt_o <= '0;
    end else if (!trap_o) begin
      commit_o.valid <= 1'b1;
      commit_o.pc    <= pc_i;
      commit_o.inst  <= inst_i;
      commit_o.wen   <= wb_i.wen;
      commit_o.wdest <= wb_i.rd;
      commit_o.wdata <= wb_i.data;
      trap_o         <= is_trap_i;
      trap_code_o    <= x10_i[7:0];
      instr_cnt_o    <= instr_cnt_o + 64'd1;
      cycle_cnt_o    <= cycle_cnt_o + 64'd1;
    end else begin
      commit_o.valid <= 1'b0;
    end
  end

  // nothing retires once trapped, so the pc must stay put
  a_pc_held_after_trap: assert property (@(posedge clock) disable iff (reset)
    trap_o |=> $stable(pc_i))
    else $error("pc moved after the trap to %h", pc_i);

endmodule

/* logic/core_top.sv */
// top level of the single-cycle RV64I core; fetch, commit and trap ports face the testbench
`timescale 1ns/100ps

module core_top import core_pkg::*; #(
  parameter logic [xlen-1:0] pc_start = 64'h8000_0000,
  parameter int dmem_depth = 256
) (
  input  logic            clock,
  input  logic            reset,
  output logic [xlen-1:0] pc_o,
  input  inst_u           inst_i,
  output commit_t         commit_o,
  output logic            trap_o,
  output logic [7:0]      trap_code_o,
  output logic [xlen-1:0] instr_cnt_o,
  output logic [xlen-1:0] cycle_cnt_o
);

  logic jmp;
  logic [xlen-1:0] jmp_addr;
  reg_addr_t rs1_addr, rs2_addr, rd_addr;
  logic [xlen-1:0] rs1_data, rs2_data, x10;
  logic rd_wen, is_trap;
  exe_req_t exe_req;
  mem_req_t mem_req;
  logic [xlen-1:0] alu_result, load_data;
  wb_t wb;

  if_stage #(.pc_start(pc_start)) if_stage_i (.clock(clock), .reset(reset), .jmp_i(jmp),
    .jmp_addr_i(jmp_addr), .halt_i(trap_o), .pc_o(pc_o));

  id_stage id_stage_i (.clock(clock), .reset(reset), .inst_i(inst_i), .pc_i(pc_o),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data), .rd_wen_o(rd_wen), .rd_addr_o(rd_addr), .exe_o(exe_req),
    .mem_o(mem_req), .is_trap_o(is_trap));

  exe_stage exe_stage_i (.exe_i(exe_req), .result_o(alu_result), .jmp_o(jmp),
    .jmp_addr_o(jmp_addr));

  mem_stage #(.dmem_depth(dmem_depth)) mem_stage_i (.clock(clock), .reset(reset),
    .req_i(mem_req), .addr_i(alu_result), .rdata_o(load_data));

  // write-back; x0 writes never count as writes
  assign wb.wen  = rd_wen && (rd_addr != '0);
  assign wb.rd   = rd_addr;
  assign wb.data = exe_req.is_load ? load_data : alu_result;

  regfile regfile_i (.clock(clock), .reset(reset), .rs1_addr_i(rs1_addr),
    .rs2_addr_i(rs2_addr), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .wb_i(wb),
    .x10_o(x10));

  commit_tracker commit_tracker_i (.clock(clock), .reset(reset), .pc_i(pc_o),
    .inst_i(inst_i), .wb_i(wb), .is_trap_i(is_trap), .x10_i(x10), .commit_o(commit_o),
    .trap_o(trap_o), .trap_code_o(trap_code_o), .instr_cnt_o(instr_cnt_o),
    .cycle_cnt_o(cycle_cnt_o));

endmodule

/* logic/exe_stage.sv */
// ALU and branch unit; produces the register result and the jump request
`timescale 1ns/100ps

module exe_stage import core_pkg::*; (
  input  exe_req_t        exe_i,
  output logic [xlen-1:0] result_o,
  output logic            jmp_o,
  output logic [xlen-1:0] jmp_addr_o
);

  logic [xlen-1:0] alu_res;
  logic [5:0] shamt;
  logic taken;
  logic is_link;

  assign shamt = exe_i.op2[5:0];

  always_comb begin
    case (exe_i.alu_op)
      alu_add:    alu_res = exe_i.op1 + exe_i.op2;
      alu_sub:    alu_res = exe_i.op1 - exe_i.op2;
      alu_sll:    alu_res = exe_i.op1 << shamt;
      alu_slt:    alu_res = {63'd0, $signed(exe_i.op1) < $signed(exe_i.op2)};
      alu_sltu:   alu_res = {63'd0, exe_i.op1 < exe_i.op2};
      alu_xor:    alu_res = exe_i.op1 ^ exe_i.op2;
      alu_srl:    alu_res = exe_i.op1 >> shamt;
      alu_sra:    alu_res = $unsigned($signed(exe_i.op1) >>> shamt);
      alu_or:     alu_res = exe_i.op1 | exe_i.op2;
      alu_and:    alu_res = exe_i.op1 & exe_i.op2;
      alu_pass_b: alu_res = exe_i.op2;
      default:    alu_res = exe_i.op1 + exe_i.op2;
    endcase
  end

  // conditional compare on rs1 and rs2
  always_comb begin
    case (exe_i.funct3)
      3'b000:  taken = (exe_i.op1 == exe_i.op2);
      3'b001:  taken = (exe_i.op1 != exe_i.op2);
      3'b100:  taken = $signed(exe_i.op1) < $signed(exe_i.op2);
      3'b101:  taken = $signed(exe_i.op1) >= $signed(exe_i.op2);
      3'b110:  taken = exe_i.op1 < exe_i.op2;
      3'b111:  taken = exe_i.op1 >= exe_i.op2;
      default: taken = 1'b0;
    endcase
  end

  assign is_link = (exe_i.br_kind == br_jal) || (exe_i.br_kind == br_jalr);

  always_comb begin
    case (exe_i.br_kind)
      br_jal:  jmp_o = 1'b1;
      br_jalr: jmp_o = 1'b1;
      br_cond: jmp_o = taken;
      default: jmp_o = 1'b0;
    endcase
  end

  // jalr target drops bit 0
  assign jmp_addr_o = (exe_i.br_kind == br_jalr) ?
                      ((exe_i.op1 + exe_i.imm) & ~64'd1) :
                      (exe_i.pc + exe_i.imm);

  assign result_o = is_link ? exe_i.pc + 64'd4 : alu_res;

endmodule

/* logic/id_stage.sv */
// instruction decoder; builds the execute and memory requests from one fetched word
`timescale 1ns/100ps

module id_stage import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  inst_u           inst_i,
  input  logic [xlen-1:0] pc_i,
  output reg_addr_t       rs1_addr_o,
  output reg_addr_t       rs2_addr_o,
  input  logic [xlen-1:0] rs1_data_i,
  input  logic [xlen-1:0] rs2_data_i,
  output logic            rd_wen_o,
  output reg_addr_t       rd_addr_o,
  output exe_req_t        exe_o,
  output mem_req_t        mem_o,
  output logic            is_trap_o
);

  logic [xlen-1:0] imm;
  logic [2:0] funct3;
  logic opc_known;

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_sel = alt ? alu_sub : alu_add;
      3'b001:  alu_sel = alu_sll;
      3'b010:  alu_sel = alu_slt;
      3'b011:  alu_sel = alu_sltu;
      3'b100:  alu_sel = alu_xor;
      3'b101:  alu_sel = alt ? alu_sra : alu_srl;
      3'b110:  alu_sel = alu_or;
      default: alu_sel = alu_and;
    endcase
  endfunction

  assign funct3 = inst_i.r_fmt.funct3;

  // immediate by format
  always_comb begin
    case (inst_i.r_fmt.opcode)
      op_store:  imm = {{52{inst_i.s_fmt.imm_11_5[6]}}, inst_i.s_fmt.imm_11_5,
                       inst_i.s_fmt.imm_4_0};
      op_branch: imm = {{51{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_12, inst_i.b_fmt.imm_11,
                       inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
      op_lui, op_auipc:
                 imm = {{32{inst_i.u_fmt.imm_31_12[19]}}, inst_i.u_fmt.imm_31_12, 12'h000};
      op_jal:    imm = {{43{inst_i.u_fmt.imm_31_12[19]}}, inst_i.u_fmt.imm_31_12[19],
                       inst_i.u_fmt.imm_31_12[7:0], inst_i.u_fmt.imm_31_12[8],
                       inst_i.u_fmt.imm_31_12[18:9], 1'b0};
      default:   imm = {{52{inst_i.i_fmt.imm_11_0[11]}}, inst_i.i_fmt.imm_11_0};
    endcase
  end

  assign rs1_addr_o = inst_i.r_fmt.rs1;
  assign rs2_addr_o = inst_i.s_fmt.rs2;
  assign rd_addr_o  = inst_i.u_fmt.rd;

  always_comb begin
    exe_o        = '0;
    exe_o.alu_op = alu_add;
    exe_o.funct3 = funct3;
    exe_o.imm    = imm;
    exe_o.pc     = pc_i;
    exe_o.op1    = rs1_data_i;
    exe_o.op2    = imm;
    mem_o        = '0;
    mem_o.size_d = (funct3 == 3'b011);
    mem_o.wdata  = rs2_data_i;
    rd_wen_o     = 1'b0;
    is_trap_o    = 1'b0;
    opc_known    = 1'b1;
    case (inst_i.r_fmt.opcode)
      op_lui: begin
        exe_o.op1    = '0;
        exe_o.alu_op = alu_pass_b;
        rd_wen_o     = 1'b1;
      end
      op_auipc: begin
        exe_o.op1 = pc_i;
        rd_wen_o  = 1'b1;
      end
      op_jal: begin
        exe_o.op1     = pc_i;
        exe_o.br_kind = br_jal;
        rd_wen_o      = 1'b1;
      end
      op_jalr: begin
        exe_o.br_kind = br_jalr;
        rd_wen_o      = 1'b1;
      end
      op_branch: begin
        exe_o.op2     = rs2_data_i;
        exe_o.br_kind = br_cond;
      end
      op_load: begin
        exe_o.is_load = 1'b1;
        mem_o.ren     = 1'b1;
        rd_wen_o      = 1'b1;
      end
      op_store: mem_o.wen = 1'b1;
      op_imm: begin
        // bit 30 only selects srai
        exe_o.alu_op = alu_sel(funct3, funct3 == 3'b101 && inst_i.r_fmt.funct7[5]);
        rd_wen_o     = 1'b1;
      end
      op_reg: begin
        exe_o.op2    = rs2_data_i;
        exe_o.alu_op = alu_sel(funct3, inst_i.r_fmt.funct7[5]);
        rd_wen_o     = 1'b1;
      end
      op_trap: is_trap_o = 1'b1;
      default: opc_known = 1'b0;
    endcase
  end

  a_known_opcode: assert property (@(posedge clock) disable iff (reset) opc_known)
    else $error("unsupported opcode %h at pc %h", inst_i.r_fmt.opcode, pc_i);

endmodule

/* logic/if_stage.sv */
// program counter of the core; drives the fetch address and follows jumps
`timescale 1ns/100ps

module if_stage import core_pkg::*; #(
  parameter logic [xlen-1:0] pc_start = 64'h8000_0000
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            jmp_i,
  input  logic [xlen-1:0] jmp_addr_i,
  input  logic            halt_i,
  output logic [xlen-1:0] pc_o
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_next;

  assign pc_next = jmp_i ? jmp_addr_i : pc + 64'd4;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= pc_start;
    end else if (!halt_i) begin
      pc <= pc_next;
    end
  end

  // frozen once the trap has been taken
  assign pc_o = pc;

endmodule

/* logic/mem_stage.sv */
// local data memory, word and double-word access with byte-masked stores
`timescale 1ns/100ps

module mem_stage import core_pkg::*; #(
  parameter int dmem_depth = 256
) (
  input  logic            clock,
  input  logic            reset,
  input  mem_req_t        req_i,
  input  logic [xlen-1:0] addr_i,
  output logic [xlen-1:0] rdata_o
);

  localparam int aw = $clog2(dmem_depth);

  logic [xlen-1:0] mem [dmem_depth];
  logic [aw-1:0] idx;
  logic [xlen-1:0] wmask;
  logic [xlen-1:0] wdata;
  logic [xlen-1:0] word;

  assign idx = addr_i[aw+2:3];

  // sw lands in one half, chosen by address bit 2
  assign wmask = req_i.size_d ? '1 :
                 addr_i[2] ? {32'hffff_ffff, 32'h0} : {32'h0, 32'hffff_ffff};
  assign wdata = req_i.size_d ? req_i.wdata : {2{req_i.wdata[31:0]}};

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < dmem_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (req_i.wen) begin
      mem[idx] <= (mem[idx] & ~wmask) | (wdata & wmask);
    end
  end

  assign word = mem[idx];

  always_comb begin
    if (!req_i.ren) rdata_o = '0;
    else if (req_i.size_d) rdata_o = word;
    else if (addr_i[2]) rdata_o = {{32{word[63]}}, word[63:32]};
    else rdata_o = {{32{word[31]}}, word[31:0]};
  end

  a_store_aligned: assert property (@(posedge clock) disable iff (reset)
    req_i.wen |-> (req_i.size_d ? addr_i[2:0] == 3'b000 : addr_i[1:0] == 2'b00))
    else $error("misaligned store to %h", addr_i);

endmodule

/* logic/regfile.sv */
// integer register file, two asynchronous reads and one clocked write
`timescale 1ns/100ps

module regfile import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  reg_addr_t       rs1_addr_i,
  input  reg_addr_t       rs2_addr_i,
  output logic [xlen-1:0] rs1_data_o,
  output logic [xlen-1:0] rs2_data_o,
  input  wb_t             wb_i,
  output logic [xlen-1:0] x10_o
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.wen && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // x0 hard zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  // a0 carries the trap code
  assign x10_o = regs[10];

endmodule

/* sim/commit_checker.sv */
// watches the core's commit and trap ports and compares them with the expected records
`timescale 1ns/100ps

module commit_checker import core_pkg::*; #(
  parameter logic [63:0] pc_start = 64'h8000_0000,
  parameter int max_commits = 64
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [63:0] pc_i,
  input  logic [31:0] fetch_i,
  input  commit_t     commit_i,
  input  logic        trap_i,
  input  logic [7:0]  trap_code_i,
  input  logic [63:0] instr_cnt_i,
  input  logic [63:0] cycle_cnt_i,
  input  logic [63:0] exp_pc_i [max_commits],
  input  logic [4:0]  exp_rd_i [max_commits],
  input  logic [63:0] exp_data_i [max_commits],
  input  int          exp_count_i,
  input  logic [7:0]  exp_code_i,
  input  logic [63:0] exp_instr_i,
  output int          errs_o,
  output int          checked_o
);

  int errs = 0;
  int n = 0;
  logic trap_seen = 1'b0;
  logic rst_q;
  logic [31:0] fetch_q;

  assign errs_o = errs;
  assign checked_o = n;

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      errs++;
      $display("Fail at %0d ns: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // rd 0 in the record means no register write
  task automatic check_commit(input int idx);
    compare_value("commit_o.pc", exp_pc_i[idx], commit_i.pc);
    compare_value("commit_o.inst", 64'(fetch_q), 64'(commit_i.inst));
    compare_value("commit_o.wen", 64'(exp_rd_i[idx] != 5'd0), 64'(commit_i.wen));
    if (exp_rd_i[idx] != 5'd0) begin
      compare_value("commit_o.wdest", 64'(exp_rd_i[idx]), 64'(commit_i.wdest));
      compare_value("commit_o.wdata", exp_data_i[idx], commit_i.wdata);
    end
  endtask

  // word on the fetch port when the record was taken
  always @(posedge clock) begin
    rst_q <= reset;
    fetch_q <= fetch_i;
  end

  always @(negedge clock) begin
    if (rst_q) begin
      compare_value("commit_o.valid", 64'd0, 64'(commit_i.valid));
      compare_value("trap_o", 64'd0, 64'(trap_i));
      compare_value("pc_o", pc_start, pc_i);
    end else begin
      if (commit_i.valid && trap_seen) begin
        errs++;
        $display("a commit at pc %h followed the trap", commit_i.pc);
      end else if (commit_i.valid && n >= exp_count_i) begin
        errs++;
        $display("a commit at pc %h came after the last expected record", commit_i.pc);
      end else if (commit_i.valid) begin
        check_commit(n);
        n++;
      end
      // trap record arrives with its own commit
      if (trap_i && !trap_seen) begin
        trap_seen = 1'b1;
        compare_value("trap_code_o", 64'(exp_code_i), 64'(trap_code_i));
        compare_value("instr_cnt_o", exp_instr_i, instr_cnt_i);
        // one instruction per clock
        compare_value("cycle_cnt_o", exp_instr_i, cycle_cnt_i);
        compare_value("commit count", 64'(exp_count_i), 64'(n));
      end
    end
  end

endmodule

/* sim/core_tb.sv */
// testbench for the RV64I core; serves the program from the trace file and reports the result
`timescale 1ns/100ps

module core_tb import core_pkg::*; ();

  localparam logic [63:0] pc_start = 64'h8000_0000;
  localparam int rom_words = 64;
  localparam int max_commits = 64;

  logic clock;
  logic reset;
  logic [31:0] inst;
  logic [63:0] pc;
  commit_t commit;
  logic trap;
  logic [7:0] trap_code;
  logic [63:0] instr_cnt;
  logic [63:0] cycle_cnt;

  logic [31:0] rom [rom_words];
  logic [63:0] exp_pc [max_commits];
  logic [4:0] exp_rd [max_commits];
  logic [63:0] exp_data [max_commits];
  logic [7:0] exp_code;
  logic [63:0] exp_instr;
  int n_exp = 0;
  int tb_errs = 0;
  int chk_errs;
  int checked;
  logic loaded = 1'b0;

  core_top #(.pc_start(pc_start), .dmem_depth(256)) core_top_i (.clock(clock), .reset(reset),
    .pc_o(pc), .inst_i(inst), .commit_o(commit), .trap_o(trap), .trap_code_o(trap_code),
    .instr_cnt_o(instr_cnt), .cycle_cnt_o(cycle_cnt));

  commit_checker #(.pc_start(pc_start), .max_commits(max_commits)) commit_checker_i (
    .clock(clock), .reset(reset), .pc_i(pc), .fetch_i(inst), .commit_i(commit),
    .trap_i(trap), .trap_code_i(trap_code), .instr_cnt_i(instr_cnt),
    .cycle_cnt_i(cycle_cnt), .exp_pc_i(exp_pc), .exp_rd_i(exp_rd),
    .exp_data_i(exp_data), .exp_count_i(n_exp), .exp_code_i(exp_code),
    .exp_instr_i(exp_instr), .errs_o(chk_errs), .checked_o(checked));

  always #5 clock = ~clock;

  // nop outside the program
  function automatic logic [31:0] rom_read(input logic [63:0] addr);
    logic [63:0] offs;
    offs = (addr - pc_start) >> 2;
    if (addr < pc_start || offs >= 64'(rom_words)) begin
      return 32'h0000_0013;
    end
    return rom[int'(offs)];
  endfunction

  task automatic load_trace();
    int fd;
    int code;
    logic [7:0] kind;
    logic [63:0] f1, f2, f3;
    logic [8*160-1:0] line;
    fd = $fopen("sim/core_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file sim/core_trace.txt");
      tb_errs++;
      return;
    end
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "#") begin
        code = $fgets(line, fd);
      end else if (kind == "P") begin
        code = $fscanf(fd, "%h %h", f1, f2);
        if (f1 < pc_start || f1 >= pc_start + 64'(4 * rom_words)) begin
          $display("program address %h lies outside the instruction ROM", f1);
          tb_errs++;
        end else begin
          rom[int'((f1 - pc_start) >> 2)] = f2[31:0];
        end
      end else if (kind == "C" && n_exp < max_commits) begin
        code = $fscanf(fd, "%h %h %h", f1, f2, f3);
        exp_pc[n_exp] = f1;
        exp_rd[n_exp] = f2[4:0];
        exp_data[n_exp] = f3;
        n_exp++;
      end else if (kind == "T") begin
        code = $fscanf(fd, "%h %h", f1, f2);
        exp_code = f1[7:0];
        exp_instr = f2;
      end else begin
        $display("unknown or surplus record in the trace file");
        tb_errs++;
      end
    end
    $fclose(fd);
  endtask

  // fetch data changes on the falling edge only
  always @(negedge clock) begin
    inst = rom_read(pc);
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    inst = 32'h0000_0013;
    exp_code = '0;
    exp_instr = '0;
    // holes hold an addi x0 carrying its word index
    for (int i = 0; i < rom_words; i++) begin
      rom[i] = {12'(i), 20'h0_0013};
    end
    load_trace();
    loaded = 1'b1;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    wait (trap);
    // a few more cycles to catch a stray commit
    repeat (3) @(negedge clock);
    @(posedge clock);
    $display("errors: %0d in checks, %0d in trace; %0d of %0d commits checked",
             chk_errs, tb_errs, checked, n_exp);
    if (chk_errs == 0 && tb_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (20 * n_exp + 100) @(posedge clock);
    $display("timeout: the core reached no trap within %0d cycles", 20 * n_exp + 100);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* sim/core_trace.txt */
# P addr inst | C pc rd wdata, rd 0 for no register write | T trap_code instr_count
# all fields hex; C records in commit order
P 80000000 fffff0b7
P 80000004 00001117
P 80000008 ffb00193
P 8000000c 00800293
P 80000010 4050d233
P 80000014 40328333
P 80000018 0032b3b3
P 8000001c 00500013
P 80000020 00500433
P 80000024 10403023
P 80000028 10602223
P 8000002c 10003503
P 80000030 10002583
P 80000034 00828463
P 8000003c 0032c463
P 80000040 008006ef
P 80000048 00d68767
P 80000050 0000006b
C 80000000 01 fffffffffffff000
C 80000004 02 0000000080001004
C 80000008 03 fffffffffffffffb
C 8000000c 05 0000000000000008
C 80000010 04 fffffffffffffff0
C 80000014 06 000000000000000d
C 80000018 07 0000000000000001
C 8000001c 00 0000000000000000
C 80000020 08 0000000000000008
C 80000024 00 0000000000000000
C 80000028 00 0000000000000000
C 8000002c 0a 0000000dfffffff0
C 80000030 0b fffffffffffffff0
C 80000034 00 0000000000000000
C 8000003c 00 0000000000000000
C 80000040 0d 0000000080000044
C 80000048 0e 000000008000004c
C 80000050 00 0000000000000000
T f0 12

/* verilog.f */
common/core_pkg.sv
logic/if_stage.sv
logic/id_stage.sv
logic/exe_stage.sv
logic/regfile.sv
logic/mem_stage.sv
logic/commit_tracker.sv
logic/core_top.sv
sim/commit_checker.sv
sim/core_tb.sv
